// File: hdl/cam_geom_pkg.sv
package cam_geom_pkg;

    // width of the search word
    parameter int CAM_DATA_WIDTH = 8;

    // log2 of the number of entries
    parameter int CAM_ADDR_WIDTH = 3;

    // bits of the search word that index one match table
    parameter int CAM_SLICE_WIDTH = 4;

    // number of match tables needed to cover the word, last one may be partial
    function automatic int slice_count(
        input int data_width,
        input int slice_width
    );
        return (data_width + slice_width - 1) / slice_width;
    endfunction

endpackage

// File: hdl/cam_ctrl_pkg.sv
package cam_ctrl_pkg;

    // update sequencer states
    // an update always passes through erase, a write then continues to set
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ERASE = 2'd1,
        SEQ_SET   = 2'd2
    } seq_state_t;

endpackage

// File: hdl/cam_update_seq.sv
`timescale 1ns/10ps

module cam_update_seq #(
    parameter int DATA_WIDTH = cam_geom_pkg::CAM_DATA_WIDTH,
    parameter int ADDR_WIDTH = cam_geom_pkg::CAM_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       write_enable,
    input  logic                       erase_enable,
    input  logic [ADDR_WIDTH-1:0]      write_addr,
    input  logic [DATA_WIDTH-1:0]      cmp_din,
    input  logic [(2**ADDR_WIDTH)-1:0] entry_valid,
    output logic                       busy,
    output logic                       erase_phase,
    output logic                       erase_hit,
    output logic                       set_phase,
    output logic [ADDR_WIDTH-1:0]      op_addr,
    output logic [DATA_WIDTH-1:0]      op_data
);

    import cam_ctrl_pkg::*;

    seq_state_t state_q;
    logic       op_write_q;
    logic       accept;

    // commands seen while busy are dropped
    assign accept = (state_q == SEQ_IDLE) && (write_enable || erase_enable);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= SEQ_IDLE;
            op_write_q <= 1'b0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (accept) begin
                        state_q <= SEQ_ERASE;
                    end
                end
                // an erase command ends here while a write goes on to set the new bits
                SEQ_ERASE: begin
                    state_q <= op_write_q ? SEQ_SET : SEQ_IDLE;
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
            // write wins over erase
            if (accept) begin
                op_write_q <= write_enable;
            end
        end
    end

    // command address and word stay held for the whole update
    always_ff @(posedge clk) begin
        if (accept) begin
            op_addr <= write_addr;
            op_data <= cmp_din;
        end
    end

    assign busy        = (state_q != SEQ_IDLE);
    assign erase_phase = (state_q == SEQ_ERASE);
    assign set_phase   = (state_q == SEQ_SET);

    // the shadow word is only meaningful for an entry that was written before
    assign erase_hit = erase_phase && entry_valid[op_addr];

    // a write runs the erase phase and then the set phase
    write_seq_a: assert property (@(posedge clk) disable iff (rst)
        (accept && write_enable) |=> erase_phase ##1 set_phase ##1 !busy);

    // an erase runs the erase phase alone
    erase_seq_a: assert property (@(posedge clk) disable iff (rst)
        (accept && !write_enable) |=> erase_phase ##1 !busy);

endmodule

// File: hdl/cam_shadow_ram.sv
`timescale 1ns/10ps

module cam_shadow_ram #(
    parameter int DATA_WIDTH = cam_geom_pkg::CAM_DATA_WIDTH,
    parameter int ADDR_WIDTH = cam_geom_pkg::CAM_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out
);

    localparam int DEPTH = 2**ADDR_WIDTH;

    // current word of every entry
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= data_in;
        end
    end

    // asynchronous read, addr stays put during the erase phase
    // so the old word is stable while its rows are cleared
    assign data_out = mem[addr];

endmodule

// File: hdl/cam_slice_table.sv
`timescale 1ns/10ps

module cam_slice_table #(
    parameter int SLICE_WIDTH = cam_geom_pkg::CAM_SLICE_WIDTH,
    parameter int ADDR_WIDTH  = cam_geom_pkg::CAM_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       set_bit,
    input  logic                       clear_bit,
    input  logic [ADDR_WIDTH-1:0]      entry_addr,
    input  logic [SLICE_WIDTH-1:0]     set_key,
    input  logic [SLICE_WIDTH-1:0]     clear_key,
    input  logic [SLICE_WIDTH-1:0]     lookup_key,
    output logic [(2**ADDR_WIDTH)-1:0] match_row
);

    localparam int ENTRIES = 2**ADDR_WIDTH;
    localparam int ROWS    = 2**SLICE_WIDTH;

    // one row per slice value, one bit per entry holding that value
    logic [ENTRIES-1:0] table_q [ROWS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                table_q[r] <= '0;
            end
        end else begin
            if (clear_bit) begin
                table_q[clear_key][entry_addr] <= 1'b0;
            end
            if (set_bit) begin
                table_q[set_key][entry_addr] <= 1'b1;
            end
        end
    end

    // registered lookup, sees the table as it was before this edge
    always_ff @(posedge clk) begin
        match_row <= table_q[lookup_key];
    end

    set_clear_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(set_bit && clear_bit));

endmodule

// File: hdl/cam_valid_regs.sv
`timescale 1ns/10ps

module cam_valid_regs #(
    parameter int ADDR_WIDTH = cam_geom_pkg::CAM_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       set_valid,
    input  logic                       clear_valid,
    input  logic [ADDR_WIDTH-1:0]      entry_addr,
    output logic [(2**ADDR_WIDTH)-1:0] entry_valid
);

    localparam int ENTRIES = 2**ADDR_WIDTH;

    logic [ENTRIES-1:0] valid_q;

    // an entry is invalid from its erase phase until its set phase
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (clear_valid) begin
                valid_q[entry_addr] <= 1'b0;
            end
            if (set_valid) begin
                valid_q[entry_addr] <= 1'b1;
            end
        end
    end

    assign entry_valid = valid_q;

endmodule

// File: hdl/cam_priority_encoder.sv
`timescale 1ns/10ps

module cam_priority_encoder #(
    parameter int    ADDR_WIDTH   = cam_geom_pkg::CAM_ADDR_WIDTH,
    // "high" lets the lowest index win and "low" the highest
    parameter string LSB_PRIORITY = "low"
) (
    input  logic [(2**ADDR_WIDTH)-1:0] match_vec,
    output logic                       match,
    output logic [ADDR_WIDTH-1:0]      match_addr
);

    localparam int WIDTH = 2**ADDR_WIDTH;

    always_comb begin
        match      = 1'b0;
        match_addr = '0;
        if (LSB_PRIORITY == "high") begin
            // scan downwards so the lowest set bit is written last
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (match_vec[i]) begin
                    match      = 1'b1;
                    match_addr = ADDR_WIDTH'(i);
                end
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (match_vec[i]) begin
                    match      = 1'b1;
                    match_addr = ADDR_WIDTH'(i);
                end
            end
        end
    end

    // the reported entry matches and no entry of higher priority does
    addr_hit_a: assert final (!match || (match_vec[match_addr] && ((LSB_PRIORITY == "high")
        ? ((match_vec & ~({WIDTH{1'b1}} << match_addr)) == '0)
        : ((match_vec >> match_addr) == WIDTH'(1)))));

    // an empty vector is the only case without a match
    no_hit_a: assert final (match || (match_vec == '0));

endmodule

// File: hdl/cam.sv
`timescale 1ns/10ps

module cam #(
    parameter int DATA_WIDTH  = cam_geom_pkg::CAM_DATA_WIDTH,
    parameter int ADDR_WIDTH  = cam_geom_pkg::CAM_ADDR_WIDTH,
    parameter int SLICE_WIDTH = cam_geom_pkg::CAM_SLICE_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_enable,
    input  logic                  erase_enable,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0] cmp_din,
    input  logic [DATA_WIDTH-1:0] din,
    output logic                  busy,
    output logic                  match,
    output logic [ADDR_WIDTH-1:0] match_addr
);

    import cam_geom_pkg::*;
    import cam_ctrl_pkg::*;

    localparam int SLICE_COUNT = slice_count(DATA_WIDTH, SLICE_WIDTH);
    localparam int PAD_WIDTH   = SLICE_COUNT * SLICE_WIDTH;
    localparam int ENTRIES     = 2**ADDR_WIDTH;

    logic                  erase_phase;
    logic                  erase_hit;
    logic                  set_phase;
    logic [ADDR_WIDTH-1:0] op_addr;
    logic [DATA_WIDTH-1:0] op_data;
    logic [DATA_WIDTH-1:0] old_data;
    logic [ENTRIES-1:0]    entry_valid;
    logic [ENTRIES-1:0]    valid_q;
    logic [ENTRIES-1:0]    slice_rows [SLICE_COUNT];
    logic [ENTRIES-1:0]    match_vec;
    seq_state_t            phase;

    // words widened to whole slices, the top slice gets zero fill
    logic [PAD_WIDTH-1:0]  din_pad;
    logic [PAD_WIDTH-1:0]  old_pad;
    logic [PAD_WIDTH-1:0]  op_pad;

    assign din_pad = PAD_WIDTH'(din);
    assign old_pad = PAD_WIDTH'(old_data);
    assign op_pad  = PAD_WIDTH'(op_data);

    cam_update_seq #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_seq (
        .clk          (clk),
        .rst          (rst),
        .write_enable (write_enable),
        .erase_enable (erase_enable),
        .write_addr   (write_addr),
        .cmp_din      (cmp_din),
        .entry_valid  (entry_valid),
        .busy         (busy),
        .erase_phase  (erase_phase),
        .erase_hit    (erase_hit),
        .set_phase    (set_phase),
        .op_addr      (op_addr),
        .op_data      (op_data)
    );

    cam_shadow_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_shadow (
        .clk      (clk),
        .write    (set_phase),
        .addr     (op_addr),
        .data_in  (op_data),
        .data_out (old_data)
    );

    cam_valid_regs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_valid (
        .clk         (clk),
        .rst         (rst),
        .set_valid   (set_phase),
        .clear_valid (erase_phase),
        .entry_addr  (op_addr),
        .entry_valid (entry_valid)
    );

    for (genvar s = 0; s < SLICE_COUNT; s++) begin : g_slice
        cam_slice_table #(
            .SLICE_WIDTH (SLICE_WIDTH),
            .ADDR_WIDTH  (ADDR_WIDTH)
        ) u_table (
            .clk        (clk),
            .rst        (rst),
            .set_bit    (set_phase),
            .clear_bit  (erase_hit),
            .entry_addr (op_addr),
            .set_key    (op_pad[s*SLICE_WIDTH +: SLICE_WIDTH]),
            .clear_key  (old_pad[s*SLICE_WIDTH +: SLICE_WIDTH]),
            .lookup_key (din_pad[s*SLICE_WIDTH +: SLICE_WIDTH]),
            .match_row  (slice_rows[s])
        );
    end

    // valid mask delayed one cycle to line up with the registered table rows
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= entry_valid;
        end
    end

    // an entry matches only if every slice agrees
    always_comb begin
        match_vec = valid_q;
        for (int s = 0; s < SLICE_COUNT; s++) begin
            match_vec = match_vec & slice_rows[s];
        end
    end

    cam_priority_encoder #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .LSB_PRIORITY ("high")
    ) u_enc (
        .match_vec  (match_vec),
        .match      (match),
        .match_addr (match_addr)
    );

    assign phase = set_phase ? SEQ_SET : (erase_phase ? SEQ_ERASE : SEQ_IDLE);

    // new bits are only set right after the old ones were cleared
    set_after_erase_a: assert property (@(posedge clk) disable iff (rst)
        (phase == SEQ_SET) |-> ($past(phase) == SEQ_ERASE));

endmodule

// File: tests/cam_clk_gen.sv
`timescale 1ns/10ps

module cam_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge half a period after time zero
    always begin
        #(PERIOD_NS / 2.0);
        clk = ~clk;
    end

endmodule

// File: tests/cam_tb.sv
`timescale 1ns/10ps

module cam_tb;

    import cam_geom_pkg::*;

    localparam int DATA_WIDTH     = CAM_DATA_WIDTH;
    localparam int ADDR_WIDTH     = CAM_ADDR_WIDTH;
    localparam int SLICE_WIDTH    = CAM_SLICE_WIDTH;
    localparam int ENTRIES        = 2**ADDR_WIDTH;
    localparam int SLICES         = slice_count(DATA_WIDTH, SLICE_WIDTH);
    localparam int OP_WRITE       = 0;
    localparam int OP_ERASE       = 1;
    localparam int OP_LOOKUP      = 2;
    localparam int TABLE_ROWS     = 26;
    localparam int RANDOM_OPS     = 40;
    localparam int TIMEOUT_CYCLES = (TABLE_ROWS + RANDOM_OPS) * 20 + 50;

    logic                  clk;
    logic                  rst;
    logic                  write_enable;
    logic                  erase_enable;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic [DATA_WIDTH-1:0] cmp_din;
    logic [DATA_WIDTH-1:0] din;
    logic                  busy;
    logic                  match;
    logic [ADDR_WIDTH-1:0] match_addr;

    // operation table whose expected columns apply to lookup rows only
    int                    tbl_op         [TABLE_ROWS];
    logic [ADDR_WIDTH-1:0] tbl_addr       [TABLE_ROWS];
    logic [DATA_WIDTH-1:0] tbl_data       [TABLE_ROWS];
    logic                  tbl_match      [TABLE_ROWS];
    logic [ADDR_WIDTH-1:0] tbl_match_addr [TABLE_ROWS];
    int                    rows_loaded = 0;

    // reference model of the entries
    logic [DATA_WIDTH-1:0] model_word  [ENTRIES];
    logic                  model_valid [ENTRIES];

    int seed        = 62079;
    int cycle_count = 0;

    cam_clk_gen #(
        .PERIOD_NS (8.0)
    ) u_clk (
        .clk (clk)
    );

    cam u_dut (
        .clk          (clk),
        .rst          (rst),
        .write_enable (write_enable),
        .erase_enable (erase_enable),
        .write_addr   (write_addr),
        .cmp_din      (cmp_din),
        .din          (din),
        .busy         (busy),
        .match        (match),
        .match_addr   (match_addr)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic add_row(input int op, input int addr, input int data,
                           input bit hit, input int hit_addr);
        tbl_op[rows_loaded]         = op;
        tbl_addr[rows_loaded]       = ADDR_WIDTH'(addr);
        tbl_data[rows_loaded]       = DATA_WIDTH'(data);
        tbl_match[rows_loaded]      = hit;
        tbl_match_addr[rows_loaded] = ADDR_WIDTH'(hit_addr);
        rows_loaded++;
    endtask

    task automatic load_table();
        // empty CAM
        add_row(OP_LOOKUP, 0, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b0, 0);
        // single word then keys off by one slice
        add_row(OP_WRITE,  3, 8'h5a, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b1, 3);
        add_row(OP_LOOKUP, 0, 8'h5b, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h4a, 1'b0, 0);
        // duplicates resolve to the lowest address
        add_row(OP_WRITE,  6, 8'h5a, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b1, 3);
        add_row(OP_WRITE,  1, 8'h5a, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b1, 1);
        // overwrite drops the old word
        add_row(OP_WRITE,  1, 8'hc3, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b1, 3);
        add_row(OP_LOOKUP, 0, 8'hc3, 1'b1, 1);
        // erase
        add_row(OP_ERASE,  3, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b1, 6);
        add_row(OP_ERASE,  6, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h5a, 1'b0, 0);
        add_row(OP_ERASE,  5, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'hc3, 1'b1, 1);
        add_row(OP_WRITE,  0, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'h00, 1'b1, 0);
        add_row(OP_WRITE,  7, 8'hc3, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'hc3, 1'b1, 1);
        add_row(OP_ERASE,  1, 8'h00, 1'b0, 0);
        add_row(OP_LOOKUP, 0, 8'hc3, 1'b1, 7);
        add_row(OP_LOOKUP, 0, 8'hc5, 1'b0, 0);
    endtask

    // lowest valid entry holding the key
    task automatic predict_lookup(input logic [DATA_WIDTH-1:0] key, output logic hit,
                                  output logic [ADDR_WIDTH-1:0] addr);
        hit  = 1'b0;
        addr = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (!hit && model_valid[i] && model_word[i] == key) begin
                hit  = 1'b1;
                addr = ADDR_WIDTH'(i);
            end
        end
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_command(input int op, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data);
        int    busy_cycles;
        int    expected_cycles;
        string op_name;
        expected_cycles = (op == OP_WRITE) ? 2 : 1;
        op_name         = (op == OP_WRITE) ? "write" : "erase";
        wait_idle();
        write_enable = (op == OP_WRITE);
        erase_enable = (op == OP_ERASE);
        write_addr   = addr;
        cmp_din      = data;
        @(posedge clk);
        #1;
        write_enable = 1'b0;
        erase_enable = 1'b0;
        busy_cycles  = 0;
        while (busy) begin
            busy_cycles++;
            @(posedge clk);
            #1;
        end
        assert (busy_cycles == expected_cycles) else begin
            $display("mismatch at %0t: busy high %0d cycles after %s of entry %0d, expected %0d",
                     $time, busy_cycles, op_name, addr, expected_cycles);
            abort_run();
        end
        model_valid[addr] = (op == OP_WRITE);
        if (op == OP_WRITE) begin
            model_word[addr] = data;
        end
    endtask

    task automatic run_lookup(input logic [DATA_WIDTH-1:0] key, input bit from_table,
                              input logic tbl_hit, input logic [ADDR_WIDTH-1:0] tbl_hit_addr);
        logic                  exp_hit;
        logic [ADDR_WIDTH-1:0] exp_addr;
        predict_lookup(key, exp_hit, exp_addr);
        if (from_table) begin
            assert (exp_hit == tbl_hit && (!tbl_hit || exp_addr == tbl_hit_addr)) else begin
                $display("reference model and operation table disagree on key %h", key);
                abort_run();
            end
        end
        din = key;
        @(posedge clk);
        #1;
        assert (match == exp_hit && (!exp_hit || match_addr == exp_addr)) else begin
            $display("mismatch at %0t: key %h gave match=%b addr=%0d, expected match=%b addr=%0d",
                     $time, key, match, match_addr, exp_hit, exp_addr);
            abort_run();
        end
    endtask

    initial begin : main
        int                    op;
        int                    slice;
        logic [31:0]           pick;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] word;
        rst          = 1'b1;
        write_enable = 1'b0;
        erase_enable = 1'b0;
        write_addr   = '0;
        cmp_din      = '0;
        din          = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            model_word[i]  = '0;
            model_valid[i] = 1'b0;
        end
        load_table();
        assert (rows_loaded == TABLE_ROWS) else begin
            $display("operation table holds %0d rows instead of %0d", rows_loaded, TABLE_ROWS);
            abort_run();
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!busy) else begin
            $display("mismatch at %0t: busy=%b right after reset", $time, busy);
            abort_run();
        end

        for (int r = 0; r < TABLE_ROWS; r++) begin
            if (tbl_op[r] == OP_LOOKUP) begin
                run_lookup(tbl_data[r], 1'b1, tbl_match[r], tbl_match_addr[r]);
            end else begin
                run_command(tbl_op[r], tbl_addr[r], tbl_data[r]);
            end
        end

        // random mix that reuses stored words so lookups hit
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op    = {$random(seed)} % 3;
            addr  = ADDR_WIDTH'($random(seed));
            word  = DATA_WIDTH'($random(seed));
            pick  = $random(seed);
            slice = pick[7:4] % SLICES;
            if (op == OP_LOOKUP) begin
                if (pick[0]) begin
                    word = model_word[addr];
                end
                // near miss in a single slice
                if (pick[1]) begin
                    word = word ^ (DATA_WIDTH'(1) << (slice * SLICE_WIDTH));
                end
                run_lookup(word, 1'b0, 1'b0, '0);
            end else begin
                if (op == OP_WRITE && pick[0]) begin
                    word = model_word[pick[10:8] % ENTRIES];
                end
                run_command(op, addr, word);
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tb.f
hdl/cam_geom_pkg.sv
hdl/cam_ctrl_pkg.sv
hdl/cam_update_seq.sv
hdl/cam_shadow_ram.sv
hdl/cam_slice_table.sv
hdl/cam_valid_regs.sv
hdl/cam_priority_encoder.sv
hdl/cam.sv
tests/cam_clk_gen.sv
tests/cam_tb.sv
